//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := btbTb
FILELIST := btb.f
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- btb.f
design/btbPkg.sv
design/btbRam.sv
design/btbPredictor.sv
design/btbTop.sv
dv/btbTb.sv

//--- design/btbPkg.sv
package btbPkg;

  localparam int addrWidth = 14;
  localparam int idxWidth = 5;
  localparam int tagWidth = addrWidth - idxWidth;

  typedef logic [addrWidth-1:0] fetchAddrT;
  typedef logic [idxWidth-1:0] btbIdxT;
  typedef logic [tagWidth-1:0] btbTagT;

  // two-bit hysteresis whose upper half predicts taken.
  typedef enum logic [1:0] {
    strongNot   = 2'd0,
    weakNot     = 2'd1,
    weakTaken   = 2'd2,
    strongTaken = 2'd3
  } hystT;

  typedef struct packed {
    btbTagT    tag;
    logic      valid;
    fetchAddrT target;
    hystT      hyst;
  } btbEntryT;

  typedef struct packed {
    btbTagT tag;
    logic   valid;
    hystT   hyst;
  } rtbEntryT;

  localparam int btbWidth = $bits(btbEntryT);
  localparam int rtbWidth = $bits(rtbEntryT);

  typedef struct packed {
    logic goF;
    logic goD;
    logic goE;
    logic goC;
  } pipeGoT;

  typedef struct packed {
    fetchAddrT exa;
    fetchAddrT taddr;
    logic      brEd;
    logic      rtsEd;
    logic      ctrue;
    logic      btErr;
    logic      rtsR;
  } exUpdateT;

  function automatic btbIdxT addrIdx(fetchAddrT addr);
    return addr[idxWidth-1:0];
  endfunction

  function automatic btbTagT addrTag(fetchAddrT addr);
    return addr[addrWidth-1:idxWidth];
  endfunction

  function automatic logic predTaken(hystT hyst);
    return (hyst == weakTaken) || (hyst == strongTaken);
  endfunction

endpackage

//--- design/btbPredictor.sv
module btbPredictor (
  input  logic              BTBCLK,
  input  logic              rst,
  input  logic              tbEn,
  input  btbPkg::pipeGoT    go,
  input  btbPkg::exUpdateT  ex,
  input  btbPkg::fetchAddrT ifa,
  input  btbPkg::fetchAddrT ifaNext,
  output btbPkg::btbIdxT    bRdIdx,
  input  btbPkg::btbEntryT  bRdData,
  output btbPkg::btbIdxT    bWrIdx,
  output btbPkg::btbEntryT  bWrData,
  output logic              bWrEn,
  output btbPkg::btbIdxT    rRdIdx,
  input  btbPkg::rtbEntryT  rRdData,
  output btbPkg::btbIdxT    rWrIdx,
  output btbPkg::rtbEntryT  rWrData,
  output logic              rWrEn,
  output logic              bTakenI,
  output logic              rTakenI,
  output btbPkg::fetchAddrT targetI,
  output logic              pTakenR,
  output logic              pTakenE
);
  import btbPkg::*;

  // last write seen by the read-after-write guard.
  logic   wrCycPrev;
  btbIdxT wrIdxPrev;
  hystT   wrHystPrev;

  logic conflictI;
  hystT bHystI;
  hystT rHystI;
  logic bHitI;
  logic rHitI;

  logic     bHitR;
  logic     rHitR;
  logic     bTakenR;
  btbEntryT bEntR;
  rtbEntryT rEntR;
  btbEntryT carryR;

  logic     bHitE;
  logic     rHitE;
  logic     bTakenE;
  btbEntryT carryE;
  hystT     nextHystE;
  logic     wrAny;

  // I stage.
  assign bRdIdx = go.goF ? addrIdx(ifaNext) : addrIdx(ifa);
  assign rRdIdx = bRdIdx;

  assign conflictI = !tbEn || (wrCycPrev && (wrIdxPrev == addrIdx(ifa)));

  // table still holds the stale counter on a conflict.
  assign bHystI = conflictI ? wrHystPrev : bRdData.hyst;
  assign rHystI = conflictI ? wrHystPrev : rRdData.hyst;

  assign bHitI = (bRdData.tag == addrTag(ifa)) && bRdData.valid && !conflictI;
  assign rHitI = (rRdData.tag == addrTag(ifa)) && rRdData.valid && !conflictI;

  assign bTakenI = bHitI && predTaken(bHystI);
  assign rTakenI = rHitI && predTaken(rHystI);
  assign targetI = bRdData.target;

  // R stage.
  always_ff @(posedge BTBCLK) begin
    if (rst) begin
      bHitR   <= 1'b0;
      rHitR   <= 1'b0;
      bTakenR <= 1'b0;
    end else if (go.goD && tbEn) begin
      bHitR   <= bHitI;
      rHitR   <= rHitI;
      bTakenR <= bTakenI;
    end
  end

  always_ff @(posedge BTBCLK) begin
    if (go.goD && tbEn) begin
      bEntR <= '{tag: bRdData.tag, valid: bRdData.valid,
                 target: bRdData.target, hyst: bHystI};
      rEntR <= '{tag: rRdData.tag, valid: rRdData.valid, hyst: rHystI};
    end
  end

  always_ff @(posedge BTBCLK) begin
    if (rst) begin
      pTakenR <= 1'b0;
    end else if (go.goD) begin
      pTakenR <= bTakenI || rTakenI;
    end
  end

  // returns carry no target.
  assign carryR = ex.rtsR ? '{tag: rEntR.tag, valid: rEntR.valid,
                              target: '0, hyst: rEntR.hyst}
                          : bEntR;

  // E stage.
  always_ff @(posedge BTBCLK) begin
    if (rst) begin
      bHitE   <= 1'b0;
      rHitE   <= 1'b0;
      bTakenE <= 1'b0;
      pTakenE <= 1'b0;
    end else if (go.goE) begin
      bHitE   <= bHitR;
      rHitE   <= rHitR;
      bTakenE <= bTakenR;
      pTakenE <= pTakenR;
    end
  end

  always_ff @(posedge BTBCLK) begin
    if (go.goE) begin
      carryE <= carryR;
    end
  end

  // saturating step.
  always_comb begin
    case (carryE.hyst)
      strongNot: nextHystE = ex.ctrue ? weakNot : strongNot;
      weakNot:   nextHystE = ex.ctrue ? weakTaken : strongNot;
      weakTaken: nextHystE = ex.ctrue ? strongTaken : weakNot;
      default:   nextHystE = ex.ctrue ? strongTaken : weakTaken;
    endcase
  end

  always_comb begin
    bWrData      = carryE;
    bWrData.hyst = nextHystE;
    if (!bHitE) begin
      bWrData.tag    = addrTag(ex.exa); // fresh allocation.
      bWrData.valid  = 1'b1;
      bWrData.target = ex.taddr;
    end else if (ex.ctrue && (!bTakenE || ex.btErr)) begin
      bWrData.target = ex.taddr;
    end
  end

  always_comb begin
    if (rHitE) begin
      rWrData = '{tag: carryE.tag, valid: carryE.valid, hyst: nextHystE};
    end else begin
      rWrData = '{tag: addrTag(ex.exa), valid: 1'b1, hyst: nextHystE};
    end
  end

  // commit.
  assign bWrEn  = go.goC && ex.brEd && (bHitE || ex.ctrue);
  assign rWrEn  = go.goC && ex.rtsEd && (rHitE || ex.ctrue);
  assign bWrIdx = addrIdx(ex.exa);
  assign rWrIdx = bWrIdx;
  assign wrAny  = bWrEn || rWrEn;

  always_ff @(posedge BTBCLK) begin
    if (rst) begin
      wrCycPrev <= 1'b0;
    end else begin
      wrCycPrev <= wrAny;
    end
  end

  always_ff @(posedge BTBCLK) begin
    if (wrAny) begin
      wrIdxPrev  <= bWrIdx;
      wrHystPrev <= nextHystE;
    end
  end

  oneTableWrite: assert property (@(posedge BTBCLK) disable iff (rst)
    !(bWrEn && rWrEn));

  // a committed branch always leaves a valid entry behind.
  bWrAtCommit: assert property (@(posedge BTBCLK) disable iff (rst)
    bWrEn |-> go.goC && bWrData.valid);

endmodule

//--- design/btbRam.sv
module btbRam #(
  parameter int entryWidth = btbPkg::btbWidth
) (
  input  logic                  BTBCLK,
  input  logic                  rst,
  input  btbPkg::btbIdxT        rdIdx,
  output logic [entryWidth-1:0] rdData,
  input  btbPkg::btbIdxT        wrIdx,
  input  logic [entryWidth-1:0] wrData,
  input  logic                  wrEn
);
  import btbPkg::*;

  localparam int depth = 1 << idxWidth;
  // valid sits right below the tag in both entry layouts.
  localparam int validPos = entryWidth - tagWidth - 1;

  logic [entryWidth-1:0] mem [depth];
  logic [depth-1:0]      validVec;
  logic [entryWidth-1:0] rdWord;
  logic                  rdValid;

  always_ff @(posedge BTBCLK) begin
    if (wrEn) begin
      mem[wrIdx] <= wrData;
    end
  end

  always_ff @(posedge BTBCLK) begin
    rdWord <= mem[rdIdx]; // old data on same-edge write.
  end

  always_ff @(posedge BTBCLK) begin
    if (rst) begin
      validVec <= '0;
      rdValid  <= 1'b0;
    end else begin
      if (wrEn) begin
        validVec[wrIdx] <= wrData[validPos];
      end
      rdValid <= validVec[rdIdx];
    end
  end

  always_comb begin
    rdData           = rdWord;
    rdData[validPos] = rdValid;
  end

  wrIdxKnown: assert property (@(posedge BTBCLK) disable iff (rst)
    wrEn |-> !$isunknown(wrIdx));

endmodule

//--- design/btbTop.sv
module btbTop (
  input  logic              BTBCLK,
  input  logic              rst,
  input  btbPkg::pipeGoT    go,
  input  btbPkg::exUpdateT  ex,
  input  logic              tbEn,
  input  btbPkg::fetchAddrT ifa,
  input  btbPkg::fetchAddrT ifaNext,
  output logic              bTakenI,
  output logic              rTakenI,
  output btbPkg::fetchAddrT targetI,
  output logic              pTakenR,
  output logic              pTakenE
);
  import btbPkg::*;

  btbIdxT   bRdIdx;
  btbIdxT   bWrIdx;
  btbEntryT bRdData;
  btbEntryT bWrData;
  logic     bWrEn;

  btbIdxT   rRdIdx;
  btbIdxT   rWrIdx;
  rtbEntryT rRdData;
  rtbEntryT rWrData;
  logic     rWrEn;

  btbPredictor predictor_i (
    .BTBCLK  (BTBCLK),
    .rst     (rst),
    .tbEn    (tbEn),
    .go      (go),
    .ex      (ex),
    .ifa     (ifa),
    .ifaNext (ifaNext),
    .bRdIdx  (bRdIdx),
    .bRdData (bRdData),
    .bWrIdx  (bWrIdx),
    .bWrData (bWrData),
    .bWrEn   (bWrEn),
    .rRdIdx  (rRdIdx),
    .rRdData (rRdData),
    .rWrIdx  (rWrIdx),
    .rWrData (rWrData),
    .rWrEn   (rWrEn),
    .bTakenI (bTakenI),
    .rTakenI (rTakenI),
    .targetI (targetI),
    .pTakenR (pTakenR),
    .pTakenE (pTakenE)
  );

  // branch table holding tag, valid, target and counter.
  btbRam #(.entryWidth(btbWidth)) bTable_i (
    .BTBCLK (BTBCLK),
    .rst    (rst),
    .rdIdx  (bRdIdx),
    .rdData (bRdData),
    .wrIdx  (bWrIdx),
    .wrData (bWrData),
    .wrEn   (bWrEn)
  );

  btbRam #(.entryWidth(rtbWidth)) rTable_i (
    .BTBCLK (BTBCLK),
    .rst    (rst),
    .rdIdx  (rRdIdx),
    .rdData (rRdData),
    .wrIdx  (rWrIdx),
    .wrData (rWrData),
    .wrEn   (rWrEn)
  );

endmodule

//--- dv/btbTb.sv
module btbTb;
  timeunit 1ns;
  timeprecision 100ps;
  import btbPkg::*;

  localparam int maxCycles = 2000; // tests need about 250 cycles.

  logic      BTBCLK;
  logic      rst;
  logic      tbEn;
  pipeGoT    go;
  exUpdateT  ex;
  fetchAddrT ifa;
  fetchAddrT ifaNext;
  logic      bTakenI;
  logic      rTakenI;
  fetchAddrT targetI;
  logic      pTakenR;
  logic      pTakenE;

  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int checksAtStart = 0;
  int errorsAtStart = 0;

  // reference model keeps each counter as a lo..hi range until it is known.
  btbTagT    bTagM [32];
  logic      bValidM [32];
  fetchAddrT bTargetM [32];
  hystT      bLoM [32];
  hystT      bHiM [32];
  btbTagT    rTagM [32];
  logic      rValidM [32];
  hystT      rLoM [32];
  hystT      rHiM [32];

  fetchAddrT addrA;
  fetchAddrT addrB;
  fetchAddrT addrD;
  fetchAddrT addrN;
  fetchAddrT tA;
  fetchAddrT tB1;
  fetchAddrT tB2;

  btbTop btbTop_i (.*);

  always #50 BTBCLK = ~BTBCLK;

  always @(posedge BTBCLK) cycleCount <= cycleCount + 1;

  initial begin
    while (cycleCount < maxCycles) @(posedge BTBCLK);
    $display("timeout: run did not finish within %0d cycles", maxCycles);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic fetchAddrT randAddr();
    logic [31:0] r;
    r = $urandom;
    return r[addrWidth-1:0];
  endfunction

  function automatic logic takenSide(hystT h);
    return h inside {weakTaken, strongTaken};
  endfunction

  function automatic hystT stepHyst(hystT h, logic taken);
    if (taken) return (h == strongTaken) ? strongTaken : hystT'(h + 2'd1);
    return (h == strongNot) ? strongNot : hystT'(h - 2'd1);
  endfunction

  task automatic compareBit(string what, logic exp, logic got);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic compareAddr(string what, fetchAddrT exp, fetchAddrT got);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic compareHyst(string what, hystT exp, logic gotTaken);
    checkCount++;
    if (gotTaken !== takenSide(exp)) begin
      errorCount++;
      $display("MISMATCH at %0t: %s counter %s, taken flag %b", $time, what,
               exp.name(), gotTaken);
    end
  endtask

  task automatic nextCycle();
    @(posedge BTBCLK);
    #5;
  endtask

  task automatic fetch(fetchAddrT addr);
    nextCycle();
    go = '0;
    go.goF = 1'b1;
    ifaNext = addr;
    nextCycle();
    go = '0;
    ifa = addr;
  endtask

  task automatic pulse(logic d, logic e);
    nextCycle();
    go.goD = d;
    go.goE = e;
    nextCycle();
    go = '0;
  endtask

  // compares the I-stage outputs with the model for the address in I.
  task automatic checkPrediction(string what, fetchAddrT addr);
    btbIdxT i;
    btbTagT t;
    i = addr[idxWidth-1:0];
    t = addr[addrWidth-1:idxWidth];
    if (!(bValidM[i] && bTagM[i] == t)) begin
      compareBit({what, " bTakenI"}, 1'b0, bTakenI);
    end else begin
      if (takenSide(bLoM[i]) == takenSide(bHiM[i])) begin
        compareHyst({what, " branch"}, bLoM[i], bTakenI);
      end
      compareAddr({what, " targetI"}, bTargetM[i], targetI);
    end
    if (!(rValidM[i] && rTagM[i] == t)) begin
      compareBit({what, " rTakenI"}, 1'b0, rTakenI);
    end else if (takenSide(rLoM[i]) == takenSide(rHiM[i])) begin
      compareHyst({what, " return"}, rLoM[i], rTakenI);
    end
  endtask

  task automatic fetchCheck(string what, fetchAddrT addr);
    fetch(addr);
    @(negedge BTBCLK);
    checkPrediction(what, addr);
  endtask

  task automatic holdCheck(logic expR, logic expE);
    repeat (3) begin
      nextCycle();
      @(negedge BTBCLK);
      compareBit("held pTakenR", expR, pTakenR);
      compareBit("held pTakenE", expE, pTakenE);
    end
  endtask

  // one instruction through I, R, E and commit; overlap refetches it during commit.
  task automatic runOp(logic isRet, fetchAddrT addr, logic taken, fetchAddrT taddr,
                       logic btErr, logic overlap);
    btbIdxT i;
    btbTagT t;
    logic   hit;
    i = addr[idxWidth-1:0];
    t = addr[addrWidth-1:idxWidth];
    fetch(addr);
    pulse(1'b1, 1'b0);
    go.goE = 1'b1;
    ex.rtsR = isRet;
    nextCycle();
    go = '0;
    go.goC = 1'b1;
    go.goF = overlap;
    ifaNext = addr;
    ex = '{exa: addr, taddr: taddr, brEd: !isRet, rtsEd: isRet, ctrue: taken,
           btErr: btErr, rtsR: 1'b0};
    nextCycle();
    go = '0;
    ex.brEd = 1'b0;
    ex.rtsEd = 1'b0;
    if (overlap) ifa = addr;
    if (!isRet) begin
      hit = bValidM[i] && (bTagM[i] == t);
      if (hit || taken) begin
        if (!hit) begin
          bTagM[i] = t;
          bValidM[i] = 1'b1;
          bTargetM[i] = taddr;
        end else if (taken && (!takenSide(bLoM[i]) || btErr)) begin
          bTargetM[i] = taddr;
        end
        bLoM[i] = stepHyst(bLoM[i], taken);
        bHiM[i] = stepHyst(bHiM[i], taken);
      end
    end else begin
      hit = rValidM[i] && (rTagM[i] == t);
      if (hit || taken) begin
        rTagM[i] = t;
        rValidM[i] = 1'b1;
        rLoM[i] = stepHyst(rLoM[i], taken);
        rHiM[i] = stepHyst(rHiM[i], taken);
      end
    end
  endtask

  task automatic endTest(string name);
    $display("test %-10s checks %0d errors %0d", name, checkCount - checksAtStart,
             errorCount - errorsAtStart);
    checksAtStart = checkCount;
    errorsAtStart = errorCount;
  endtask

  task automatic testReset();
    repeat (4) fetchCheck("reset", randAddr());
    compareBit("reset pTakenR", 1'b0, pTakenR);
    compareBit("reset pTakenE", 1'b0, pTakenE);
    pulse(1'b1, 1'b0);
    pulse(1'b0, 1'b1);
    @(negedge BTBCLK);
    compareBit("empty pTakenR", 1'b0, pTakenR);
    compareBit("empty pTakenE", 1'b0, pTakenE);
    endTest("reset");
  endtask

  task automatic testAllocate();
    repeat (2) runOp(1'b0, addrA, 1'b1, tA, 1'b0, 1'b0);
    fetchCheck("alloc", addrA);
    endTest("allocate");
  endtask

  task automatic testCounter();
    repeat (4) runOp(1'b0, addrB, 1'b1, tB1, 1'b0, 1'b0);
    fetchCheck("saturated", addrB);
    runOp(1'b0, addrB, 1'b0, tB1, 1'b0, 1'b0);
    fetchCheck("one not", addrB);
    runOp(1'b0, addrB, 1'b0, tB1, 1'b0, 1'b0);
    fetchCheck("two not", addrB);
    runOp(1'b0, addrB, 1'b1, tB1, 1'b0, 1'b0);
    runOp(1'b0, addrB, 1'b1, tB2, 1'b1, 1'b0);
    fetchCheck("btErr", addrB);
    endTest("counter");
  endtask

  task automatic testTagConflict();
    fetchCheck("other tag", {addrA[addrWidth-1:idxWidth] ^ 9'h1, addrA[idxWidth-1:0]});
    runOp(1'b0, addrA, 1'b1, tA, 1'b0, 1'b1);
    @(negedge BTBCLK);
    compareBit("conflict bTakenI", 1'b0, bTakenI); // write one edge ago.
    compareBit("conflict rTakenI", 1'b0, rTakenI);
    nextCycle();
    @(negedge BTBCLK);
    checkPrediction("after write", addrA);
    nextCycle();
    tbEn = 1'b0;
    fetch(addrA);
    @(negedge BTBCLK);
    compareBit("disabled bTakenI", 1'b0, bTakenI);
    compareBit("disabled rTakenI", 1'b0, rTakenI);
    nextCycle();
    tbEn = 1'b1;
    endTest("tag");
  endtask

  task automatic testReturn();
    repeat (2) runOp(1'b1, addrD, 1'b1, '0, 1'b0, 1'b0);
    fetchCheck("return", addrD);
    fetchCheck("branch kept", addrA);
    endTest("return");
  endtask

  task automatic testPipeFlags();
    logic expB;
    expB = takenSide(bLoM[addrB[idxWidth-1:0]]); // strongTaken after counter test.
    fetch(addrN);
    pulse(1'b1, 1'b0);
    pulse(1'b0, 1'b1);
    fetch(addrB);
    @(negedge BTBCLK);
    compareBit("no goD pTakenR", 1'b0, pTakenR);
    holdCheck(1'b0, 1'b0);
    pulse(1'b1, 1'b0);
    @(negedge BTBCLK);
    compareBit("goD pTakenR", expB, pTakenR);
    compareBit("goD pTakenE", 1'b0, pTakenE);
    holdCheck(expB, 1'b0);
    pulse(1'b0, 1'b1);
    holdCheck(expB, expB);
    fetch(addrN);
    pulse(1'b1, 1'b0);
    holdCheck(1'b0, expB);
    endTest("pipeline");
  endtask

  initial begin
    btbIdxT base;
    void'($urandom(32'h55be));
    BTBCLK = 1'b0;
    rst = 1'b1;
    tbEn = 1'b1;
    go = '0;
    ex = '0;
    ifa = '0;
    ifaNext = '0;
    for (int i = 0; i < 32; i++) begin
      bValidM[i] = 1'b0;
      rValidM[i] = 1'b0;
      bTagM[i] = '0;
      rTagM[i] = '0;
      bTargetM[i] = '0;
      bLoM[i] = strongNot; // unwritten counter could hold anything.
      bHiM[i] = strongTaken;
      rLoM[i] = strongNot;
      rHiM[i] = strongTaken;
    end
    base = btbIdxT'(randAddr());
    addrA = {btbTagT'(randAddr()), base};
    addrB = {btbTagT'(randAddr()), btbIdxT'(base + 5'd1)};
    addrD = {btbTagT'(randAddr()), btbIdxT'(base + 5'd2)};
    addrN = {btbTagT'(randAddr()), btbIdxT'(base + 5'd3)};
    tA = randAddr();
    tB1 = randAddr();
    tB2 = tB1 ^ 14'h2a5;
    repeat (16) @(posedge BTBCLK);
    #5;
    rst = 1'b0;

    testReset();
    testAllocate();
    testCounter();
    testTagConflict();
    testReturn();
    testPipeFlags();

    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
